// File: sparcFrontEnd.f
src/sparcPkg.sv
src/stageRegister.sv
src/instrDecoder.sv
src/fetchUnit.sv
src/registerFile.sv
src/sparcFrontEnd.sv
verif/frontEndChecker.sv
verif/tbSparcFrontEnd.sv

// File: verif/tbSparcFrontEnd.sv
`timescale 1ns/1ps

module tbSparcFrontEnd
    import sparcPkg::*;
();

    localparam int runCycles = 400;
    localparam int drainTimeout = 20;

    logic Clk;
    logic reset;
    logic [wordWidth-1:0] instr;
    logic advance;
    logic stall;
    logic branchTaken;
    logic jmplTaken;
    logic [wordWidth-1:0] jmplTarget;
    logic wbEnable;
    logic [regAddrWidth-1:0] wbReg;
    logic [wordWidth-1:0] wbData;
    logic [wordWidth-1:0] fetchAddr;
    controlWordT exControl;
    logic [wordWidth-1:0] exPc;
    logic [wordWidth-1:0] exOperandA;
    logic [wordWidth-1:0] exOperandB;
    logic [wordWidth-1:0] exStoreData;
    logic [21:0] exImm22;
    logic [regAddrWidth-1:0] exRd;
    int errorCount;
    int checkCount;
    int checksAtEnd;
    int waitCycles;
    int idx;
    bit timedOut;

    sparcFrontEnd #(
        .resetPc('0),
        .numRegs(32)
    ) i_sparcFrontEnd (
        .Clk(Clk),
        .reset(reset),
        .instr(instr),
        .advance(advance),
        .stall(stall),
        .branchTaken(branchTaken),
        .jmplTaken(jmplTaken),
        .jmplTarget(jmplTarget),
        .wbEnable(wbEnable),
        .wbReg(wbReg),
        .wbData(wbData),
        .fetchAddr(fetchAddr),
        .exControl(exControl),
        .exPc(exPc),
        .exOperandA(exOperandA),
        .exOperandB(exOperandB),
        .exStoreData(exStoreData),
        .exImm22(exImm22),
        .exRd(exRd)
    );

    frontEndChecker #(
        .resetPc('0)
    ) i_checker (
        .Clk(Clk),
        .reset(reset),
        .instr(instr),
        .advance(advance),
        .stall(stall),
        .branchTaken(branchTaken),
        .jmplTaken(jmplTaken),
        .jmplTarget(jmplTarget),
        .wbEnable(wbEnable),
        .wbReg(wbReg),
        .wbData(wbData),
        .fetchAddr(fetchAddr),
        .exControl(exControl),
        .exPc(exPc),
        .exOperandA(exOperandA),
        .exOperandB(exOperandB),
        .exStoreData(exStoreData),
        .exImm22(exImm22),
        .exRd(exRd),
        .errorCount(errorCount),
        .checkCount(checkCount)
    );

    initial
    begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    // Weighted instruction classes over random filler bits
    function automatic logic [wordWidth-1:0] pickInstruction();
        int cls;
        logic [wordWidth-1:0] word;
        cls = $urandom % 100;
        word = $urandom;
        if (cls < 8)
        begin
            word[31:30] = opCall;
        end
        else if (cls < 28)
        begin
            word[31:30] = opBranch;
            word[24:22] = 3'b010; // Bicc
        end
        else if (cls < 38)
        begin
            word[31:30] = opBranch;
            word[24:22] = 3'b100; // Sethi
        end
        else if (cls < 68)
        begin
            word[31:30] = opArith;
            if (word[24:19] == op3Jmpl)
            begin
                word[24:19] = 6'b000000;
            end
        end
        else if (cls < 75)
        begin
            word[31:30] = opArith;
            word[24:19] = op3Jmpl;
        end
        else if (cls < 95)
        begin
            word[31:30] = opMem;
            case ($urandom % 9)
                0: word[24:19] = 6'b001001;
                1: word[24:19] = 6'b001010;
                2: word[24:19] = 6'b000000;
                3: word[24:19] = 6'b000001;
                4: word[24:19] = 6'b000010;
                5: word[24:19] = 6'b000101;
                6: word[24:19] = 6'b000110;
                7: word[24:19] = 6'b000100;
                default: word[24:19] = 6'b001111; // Unsupported access
            endcase
        end
        else
        begin
            word = '0;
        end
        return word;
    endfunction

    task automatic driveRandomCycle();
        instr = pickInstruction();
        advance = ($urandom % 6) != 0;
        stall = ($urandom % 6) == 0;
        branchTaken = $urandom % 2;
        jmplTaken = ($urandom % 10) == 0;
        jmplTarget = $urandom & 32'hFFFF_FFFC; // Keep it word aligned
        wbEnable = ($urandom % 10) < 3;
        wbReg = $urandom % 32; // r0 included on purpose
        wbData = $urandom;
    endtask

    initial
    begin
        reset = 1'b1;
        instr = '0;
        advance = 1'b0;
        stall = 1'b0;
        branchTaken = 1'b0;
        jmplTaken = 1'b0;
        jmplTarget = '0;
        wbEnable = 1'b0;
        wbReg = '0;
        wbData = '0;
        timedOut = 1'b0;
        void'($urandom(35));
        repeat (8) @(posedge Clk);
        @(negedge Clk);
        reset = 1'b0;
        // Fill r1..r31 through the write-back port
        for (idx = 1; idx < 32; idx++)
        begin
            wbEnable = 1'b1;
            wbReg = idx;
            wbData = $urandom;
            @(negedge Clk);
        end
        wbEnable = 1'b0;
        for (idx = 0; idx < runCycles; idx++)
        begin
            driveRandomCycle();
            @(negedge Clk);
        end
        advance = 1'b0;
        stall = 1'b0;
        jmplTaken = 1'b0;
        wbEnable = 1'b0;
        instr = '0;
        // Two edges to drain ID/EX, plus one spare comparison
        checksAtEnd = checkCount;
        waitCycles = 0;
        while (checkCount < checksAtEnd + 3 && waitCycles < drainTimeout)
        begin
            @(negedge Clk);
            waitCycles++;
        end
        timedOut = (checkCount < checksAtEnd + 3);
        @(posedge Clk); // Let the last counts settle
        $display("Comparisons: %0d, errors: %0d", checkCount, errorCount);
        if (timedOut)
        begin
            $display("Timed out waiting for the checker to finish comparing");
            $display("Test FAILED");
        end
        else if (errorCount == 0 && checkCount > 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verif/frontEndChecker.sv
`timescale 1ns/1ps

module frontEndChecker
    import sparcPkg::*;
#(
    parameter logic [wordWidth-1:0] resetPc = '0
)
(
    input logic Clk,
    input logic reset,
    input logic [wordWidth-1:0] instr,
    input logic advance,
    input logic stall,
    input logic branchTaken,
    input logic jmplTaken,
    input logic [wordWidth-1:0] jmplTarget,
    input logic wbEnable,
    input logic [regAddrWidth-1:0] wbReg,
    input logic [wordWidth-1:0] wbData,
    input logic [wordWidth-1:0] fetchAddr,
    input controlWordT exControl,
    input logic [wordWidth-1:0] exPc,
    input logic [wordWidth-1:0] exOperandA,
    input logic [wordWidth-1:0] exOperandB,
    input logic [wordWidth-1:0] exStoreData,
    input logic [21:0] exImm22,
    input logic [regAddrWidth-1:0] exRd,
    output int errorCount,
    output int checkCount
);

    logic [wordWidth-1:0] mPc;
    logic [wordWidth-1:0] mNpc;
    logic [wordWidth-1:0] mIfPc;
    logic [wordWidth-1:0] mIfInstr;
    logic [wordWidth-1:0] mRegs [32];
    idExT mEx; // What ID/EX should hold
    bit modelValid;

    function automatic aluOpT arithOp(input logic [3:0] sel, input logic shift);
        case (sel)
            4'd0: return add;
            4'd8: return addCarry;
            4'd4: return sub;
            4'd12: return subCarry;
            4'd1: return andOp;
            4'd2: return orOp;
            4'd3: return xorOp;
            4'd5: return shift ? sll : andNot;
            4'd6: return shift ? srl : orNot;
            4'd7: return shift ? sra : xnorOp;
            default: return add;
        endcase
    endfunction

    function automatic controlWordT expectedControl(input logic [wordWidth-1:0] word,
        input logic squash);
        controlWordT c;
        logic [5:0] op3;
        c = '0;
        op3 = word[24:19];
        if (squash || word == '0)
        begin
            return c; // Bubble or nop
        end
        case (word[31:30])
            opCall:
            begin
                c.call = 1'b1;
                c.rfEnable = 1'b1;
            end
            opBranch:
            begin
                c.rfEnable = (word[24:22] == 3'b100); // Sethi
                c.aluOp = c.rfEnable ? passB : add;
                c.branch = !c.rfEnable;
                c.annul = !c.rfEnable && word[29];
            end
            opArith:
            begin
                c.jmpl = (op3 == op3Jmpl);
                c.rfEnable = !c.jmpl;
                c.modifyCC = !c.jmpl && word[23];
                c.aluOp = c.jmpl ? add : arithOp(word[22:19], word[24]);
            end
            default:
            begin
                c.dataMemEnable = 1'b1;
                case (op3)
                    6'b001001, 6'b001010, 6'b000000, 6'b000001, 6'b000010: c.load = 1'b1;
                    6'b000101, 6'b000110, 6'b000100: c.readWrite = 1'b1;
                    default: c.load = 1'b0; // Unknown access, enable only
                endcase
                c.rfEnable = c.load;
                c.signExtend = c.load && op3[3]; // ldsb and ldsh
                if (c.load || c.readWrite)
                begin
                    c.size = (op3[1:0] == 2'b01) ? sizeByte :
                        (op3[1:0] == 2'b10) ? sizeHalf : sizeWord;
                end
            end
        endcase
        return c;
    endfunction

    function automatic logic [wordWidth-1:0] modelRead(input logic [regAddrWidth-1:0] addr);
        return (addr == '0) ? '0 : mRegs[addr];
    endfunction

    task automatic checkField(input string name, input logic [wordWidth-1:0] got,
        input logic [wordWidth-1:0] want, inout int errs);
        if (got !== want)
        begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, want);
            errs++;
        end
    endtask

    initial
    begin : modelInit
        int i;
        errorCount = 0;
        checkCount = 0;
        modelValid = 1'b0;
        for (i = 0; i < 32; i++)
        begin
            mRegs[i] = '0;
        end
    end

    always @(posedge Clk)
    begin : modelStep
        controlWordT ctrl;
        logic [wordWidth-1:0] disp;
        logic [wordWidth-1:0] nextNpc;
        if (reset)
        begin
            mPc = resetPc;
            mNpc = resetPc + 4;
            mIfPc = '0;
            mIfInstr = '0;
            mEx = '0;
            modelValid = 1'b1;
        end
        else
        begin
            ctrl = expectedControl(mIfInstr, stall);
            disp = ctrl.call ? {{2{mIfInstr[29]}}, mIfInstr[29:0]} :
                {{10{mIfInstr[21]}}, mIfInstr[21:0]}; // Word displacement
            if (jmplTaken)
            begin
                nextNpc = jmplTarget;
            end
            else if (ctrl.call || (ctrl.branch && branchTaken))
            begin
                nextNpc = mIfPc + (disp << 2);
            end
            else
            begin
                nextNpc = mNpc + 4;
            end
            // Decode stage uses IF/ID before it moves
            mEx.control = ctrl;
            mEx.pc = mIfPc;
            mEx.operandA = modelRead(mIfInstr[18:14]);
            mEx.operandB = modelRead(mIfInstr[4:0]);
            mEx.storeData = modelRead(mIfInstr[29:25]);
            mEx.imm22 = mIfInstr[21:0];
            mEx.rd = mIfInstr[29:25];
            if (ctrl.annul)
            begin
                mIfPc = '0; // Annulled slot becomes a nop
                mIfInstr = '0;
            end
            else if (advance)
            begin
                mIfPc = mPc;
                mIfInstr = instr;
            end
            if (advance)
            begin
                mPc = mNpc;
                mNpc = nextNpc;
            end
            if (wbEnable && wbReg != '0)
            begin
                mRegs[wbReg] = wbData;
            end
        end
    end

    // Outputs are all registered, so mid-cycle is a safe place to look
    always @(negedge Clk)
    begin : compareOutputs
        int errs;
        errs = 0;
        if (modelValid)
        begin
            checkField("fetchAddr", fetchAddr, mPc, errs);
            checkField("exControl", exControl, mEx.control, errs);
            checkField("exPc", exPc, mEx.pc, errs);
            checkField("exOperandA", exOperandA, mEx.operandA, errs);
            checkField("exOperandB", exOperandB, mEx.operandB, errs);
            checkField("exStoreData", exStoreData, mEx.storeData, errs);
            checkField("exImm22", exImm22, mEx.imm22, errs);
            checkField("exRd", exRd, mEx.rd, errs);
            errorCount <= errorCount + errs;
            checkCount <= checkCount + 1;
        end
    end

endmodule

// File: src/sparcFrontEnd.sv
`timescale 1ns/1ps

module sparcFrontEnd
    import sparcPkg::*;
#(
    parameter logic [wordWidth-1:0] resetPc = '0,
    parameter int numRegs = 32
)
(
    input logic Clk,
    input logic reset,
    input logic [wordWidth-1:0] instr,
    input logic advance,
    input logic stall,
    input logic branchTaken,
    input logic jmplTaken,
    input logic [wordWidth-1:0] jmplTarget,
    input logic wbEnable,
    input logic [regAddrWidth-1:0] wbReg,
    input logic [wordWidth-1:0] wbData,
    output logic [wordWidth-1:0] fetchAddr,
    output controlWordT exControl,
    output logic [wordWidth-1:0] exPc,
    output logic [wordWidth-1:0] exOperandA,
    output logic [wordWidth-1:0] exOperandB,
    output logic [wordWidth-1:0] exStoreData,
    output logic [21:0] exImm22,
    output logic [regAddrWidth-1:0] exRd
);

    ifIdT ifId;
    idExT idEx;
    controlWordT idControl;
    logic [wordWidth-1:0] readA;
    logic [wordWidth-1:0] readB;
    logic [wordWidth-1:0] readStore;

    fetchUnit #(
        .resetPc(resetPc)
    ) i_fetchUnit (
        .Clk(Clk),
        .reset(reset),
        .advance(advance),
        .idPc(ifId.pc),
        .idInstr(ifId.instr),
        .call(idControl.call),
        .branch(idControl.branch),
        .branchTaken(branchTaken),
        .jmplTaken(jmplTaken),
        .jmplTarget(jmplTarget),
        .pc(fetchAddr)
    );

    // Annulled delay slot is dropped straight out of IF/ID
    stageRegister #(
        .payloadT(ifIdT)
    ) i_ifIdReg (
        .Clk(Clk),
        .reset(reset),
        .clear(idControl.annul),
        .load(advance),
        .d(ifIdT'{pc: fetchAddr, instr: instr}),
        .q(ifId)
    );

    instrDecoder i_instrDecoder (
        .instr(ifId.instr),
        .stall(stall),
        .control(idControl)
    );

    registerFile #(
        .numRegs(numRegs)
    ) i_registerFile (
        .Clk(Clk),
        .wbEnable(wbEnable),
        .wbReg(wbReg),
        .wbData(wbData),
        .rs1(ifId.instr[18:14]),
        .rs2(ifId.instr[4:0]),
        .rd(ifId.instr[29:25]),
        .readA(readA),
        .readB(readB),
        .readStore(readStore)
    );

    // Loads every cycle, a held IF/ID just decodes again
    stageRegister #(
        .payloadT(idExT)
    ) i_idExReg (
        .Clk(Clk),
        .reset(reset),
        .clear(1'b0),
        .load(1'b1),
        .d(idExT'{control: idControl, pc: ifId.pc, operandA: readA, operandB: readB,
            storeData: readStore, imm22: ifId.instr[21:0], rd: ifId.instr[29:25]}),
        .q(idEx)
    );

    assign exControl = idEx.control;
    assign exPc = idEx.pc;
    assign exOperandA = idEx.operandA;
    assign exOperandB = idEx.operandB;
    assign exStoreData = idEx.storeData;
    assign exImm22 = idEx.imm22;
    assign exRd = idEx.rd;

endmodule

// File: src/registerFile.sv
`timescale 1ns/1ps

module registerFile
    import sparcPkg::*;
#(
    parameter int numRegs = 32
)
(
    input logic Clk,
    input logic wbEnable,
    input logic [regAddrWidth-1:0] wbReg,
    input logic [wordWidth-1:0] wbData,
    input logic [regAddrWidth-1:0] rs1,
    input logic [regAddrWidth-1:0] rs2,
    input logic [regAddrWidth-1:0] rd,
    output logic [wordWidth-1:0] readA,
    output logic [wordWidth-1:0] readB,
    output logic [wordWidth-1:0] readStore
);

    logic [wordWidth-1:0] regs [numRegs];

    // r0 is hardwired and its storage entry is never read
    function automatic logic [wordWidth-1:0] readPort(input logic [regAddrWidth-1:0] addr);
        return (addr == '0) ? '0 : regs[addr];
    endfunction

    always_ff @(posedge Clk)
    begin
        if (wbEnable && wbReg != '0)
        begin
            regs[wbReg] <= wbData;
        end
    end

    // No bypass so a same-cycle write shows up next cycle
    assign readA = readPort(rs1);
    assign readB = readPort(rs2);
    assign readStore = readPort(rd); // Store data comes from rd

    // A write-back must be readable one edge later
    assert property (@(posedge Clk) wbEnable && wbReg != '0
        |=> rs1 != $past(wbReg) || readA == $past(wbData))
    else $error("Write-back not visible on readA: %h", readA);

endmodule

// File: src/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit
    import sparcPkg::*;
#(
    parameter logic [wordWidth-1:0] resetPc = '0
)
(
    input logic Clk,
    input logic reset,
    input logic advance,
    input logic [wordWidth-1:0] idPc,
    input logic [wordWidth-1:0] idInstr,
    input logic call,
    input logic branch,
    input logic branchTaken,
    input logic jmplTaken,
    input logic [wordWidth-1:0] jmplTarget,
    output logic [wordWidth-1:0] pc
);

    logic [wordWidth-1:0] npc;
    logic [wordWidth-1:0] disp30Ext;
    logic [wordWidth-1:0] disp22Ext;
    logic [wordWidth-1:0] target;
    logic [wordWidth-1:0] nextNpc;

    // Word displacements scaled to bytes
    assign disp30Ext = {idInstr[29:0], 2'b00}; // Sign bit lands in bit 31
    assign disp22Ext = {{8{idInstr[21]}}, idInstr[21:0], 2'b00};

    // Targets are relative to the instruction in decode
    assign target = idPc + (call ? disp30Ext : disp22Ext);

    always_comb
    begin
        if (jmplTaken)
        begin
            nextNpc = jmplTarget; // Resolved in EX, wins over decode
        end
        else if (call)
        begin
            nextNpc = target;
        end
        else if (branch && branchTaken)
        begin
            nextNpc = target;
        end
        else
        begin
            nextNpc = npc + wordWidth'(4);
        end
    end

    // Delayed branching: the slot after a transfer still executes
    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            pc <= resetPc;
            npc <= resetPc + wordWidth'(4);
        end
        else if (advance)
        begin
            pc <= npc;
            npc <= nextNpc;
        end
    end

    // Misaligned pc would mean a bad jmpl target or reset value
    assert property (@(posedge Clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("Fetch address not word aligned: %h", pc);

endmodule

// File: src/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder
    import sparcPkg::*;
(
    input logic [wordWidth-1:0] instr,
    input logic stall,
    output controlWordT control
);

    logic [1:0] op;
    logic [5:0] op3;
    logic shiftSel;
    controlWordT decoded;

    assign op = instr[31:30];
    assign op3 = instr[24:19];
    assign shiftSel = instr[24]; // Picks shift over negated logic op

    always_comb
    begin
        decoded = '0;
        case (op)
            opCall:
            begin
                decoded.call = 1'b1;
                decoded.rfEnable = 1'b1; // Return address goes to r15
            end
            opBranch:
            begin
                if (instr == '0)
                begin
                    decoded = '0; // Nop
                end
                else if (instr[24:22] == 3'b100)
                begin
                    decoded.rfEnable = 1'b1; // Sethi
                    decoded.aluOp = passB;
                end
                else
                begin
                    decoded.branch = 1'b1;
                    decoded.annul = instr[29];
                end
            end
            opArith:
            begin
                if (op3 == op3Jmpl)
                begin
                    decoded.jmpl = 1'b1;
                    decoded.aluOp = add; // Target is rs1 plus operand B
                end
                else
                begin
                    decoded.rfEnable = 1'b1;
                    decoded.modifyCC = instr[23]; // The cc variants
                    case (instr[22:19])
                        4'd0: decoded.aluOp = add;
                        4'd8: decoded.aluOp = addCarry;
                        4'd4: decoded.aluOp = sub;
                        4'd12: decoded.aluOp = subCarry;
                        4'd1: decoded.aluOp = andOp;
                        4'd2: decoded.aluOp = orOp;
                        4'd3: decoded.aluOp = xorOp;
                        4'd5: decoded.aluOp = shiftSel ? sll : andNot;
                        4'd6: decoded.aluOp = shiftSel ? srl : orNot;
                        4'd7: decoded.aluOp = shiftSel ? sra : xnorOp;
                        default: decoded.aluOp = add;
                    endcase
                end
            end
            default:
            begin
                // Memory format
                decoded.dataMemEnable = 1'b1;
                case (op3)
                    6'b001001:
                    begin
                        decoded.load = 1'b1; // ldsb
                        decoded.rfEnable = 1'b1;
                        decoded.signExtend = 1'b1;
                        decoded.size = sizeByte;
                    end
                    6'b001010:
                    begin
                        decoded.load = 1'b1; // ldsh
                        decoded.rfEnable = 1'b1;
                        decoded.signExtend = 1'b1;
                        decoded.size = sizeHalf;
                    end
                    6'b000000:
                    begin
                        decoded.load = 1'b1; // ld
                        decoded.rfEnable = 1'b1;
                        decoded.size = sizeWord;
                    end
                    6'b000001:
                    begin
                        decoded.load = 1'b1; // ldub
                        decoded.rfEnable = 1'b1;
                        decoded.size = sizeByte;
                    end
                    6'b000010:
                    begin
                        decoded.load = 1'b1; // lduh
                        decoded.rfEnable = 1'b1;
                        decoded.size = sizeHalf;
                    end
                    6'b000101:
                    begin
                        decoded.readWrite = 1'b1; // stb
                        decoded.size = sizeByte;
                    end
                    6'b000110:
                    begin
                        decoded.readWrite = 1'b1; // sth
                        decoded.size = sizeHalf;
                    end
                    6'b000100:
                    begin
                        decoded.readWrite = 1'b1; // st
                        decoded.size = sizeWord;
                    end
                    default:
                    begin
                        decoded.readWrite = 1'b0; // Unsupported op3 keeps enable only
                    end
                endcase
            end
        endcase
    end

    // Hazard squash turns the slot into a nop
    assign control = stall ? controlWordT'('0) : decoded;

endmodule

// File: src/stageRegister.sv
`timescale 1ns/1ps

module stageRegister
#(
    parameter type payloadT = logic
)
(
    input logic Clk,
    input logic reset,
    input logic clear,
    input logic load,
    input payloadT d,
    output payloadT q
);

    // An all-zero payload is a bubble in either stage
    always_ff @(posedge Clk)
    begin
        if (reset || clear)
        begin
            q <= '0;
        end
        else if (load)
        begin
            q <= d;
        end
    end

endmodule

// File: src/sparcPkg.sv
package sparcPkg;

    localparam int wordWidth = 32;
    localparam int regAddrWidth = 5;

    // Major opcode, instruction bits 31:30
    localparam logic [1:0] opBranch = 2'b00;
    localparam logic [1:0] opCall = 2'b01;
    localparam logic [1:0] opArith = 2'b10;
    localparam logic [1:0] opMem = 2'b11;

    localparam logic [5:0] op3Jmpl = 6'b111000;

    // Encoding seen by the ALU in EX
    typedef enum logic [3:0] {
        add = 4'd0,
        addCarry = 4'd1,
        sub = 4'd2,
        subCarry = 4'd3,
        andOp = 4'd4,
        orOp = 4'd5,
        xorOp = 4'd6,
        xnorOp = 4'd7,
        andNot = 4'd8,
        orNot = 4'd9,
        sll = 4'd10,
        srl = 4'd11,
        sra = 4'd12,
        passB = 4'd14 // Sethi moves operand B through
    } aluOpT;

    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } memSizeT;

    typedef struct packed {
        logic jmpl;
        logic readWrite; // High for a store
        aluOpT aluOp;
        logic signExtend;
        logic load;
        logic rfEnable;
        memSizeT size;
        logic modifyCC;
        logic call;
        logic branch;
        logic annul;
        logic dataMemEnable;
    } controlWordT;

    typedef struct packed {
        logic [wordWidth-1:0] pc;
        logic [wordWidth-1:0] instr;
    } ifIdT;

    typedef struct packed {
        controlWordT control;
        logic [wordWidth-1:0] pc;
        logic [wordWidth-1:0] operandA;
        logic [wordWidth-1:0] operandB;
        logic [wordWidth-1:0] storeData;
        logic [21:0] imm22;
        logic [regAddrWidth-1:0] rd;
    } idExT;

endpackage
